/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = udp_echo_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
src/udp_echo_pkg.sv
src/byte_stream_if.sv
src/udp_hdr_if.sv
src/udp_rx_parser.sv
src/echo_filter.sv
src/echo_payload_fifo.sv
src/echo_tx_builder.sv
src/udp_echo_top.sv
testbench/udp_echo_checker.sv
testbench/udp_echo_tb.sv

/* src/byte_stream_if.sv */
// Byte stream link
`timescale 1ns/1ps

interface byte_stream_if;

    logic [7:0] data;
    logic       valid;
    logic       ready;
    logic       last;

    modport source (
        output data, valid, last,
        input  ready
    );

    modport sink (
        input  data, valid, last,
        output ready
    );

endinterface

/* src/echo_filter.sv */
// Echo match filter
`timescale 1ns/1ps

module echo_filter (
    input  logic          clk,
    input  logic          rst,
    udp_hdr_if.sink       rx_hdr,
    byte_stream_if.sink   rx_payload,
    byte_stream_if.source fifo_in,
    udp_hdr_if.source     tx_hdr
);

    udp_echo_pkg::filter_state_e state;
    udp_echo_pkg::udp_hdr_t      reply_hdr;
    logic                        reply_valid;
    logic                        payload_done;
    logic                        match;
    logic                        last_xfer;
    logic                        reply_xfer;

    assign match = (rx_hdr.hdr.dst_ip == udp_echo_pkg::LOCAL_IP) &&
                   (rx_hdr.hdr.dst_port == udp_echo_pkg::ECHO_PORT);

    assign rx_hdr.ready = state == udp_echo_pkg::FILT_IDLE;

    assign fifo_in.data  = rx_payload.data;
    assign fifo_in.last  = rx_payload.last;
    assign fifo_in.valid = rx_payload.valid && !payload_done &&
                           (state == udp_echo_pkg::FILT_FORWARD);

    always_comb begin
        case (state)
            udp_echo_pkg::FILT_FORWARD: rx_payload.ready = fifo_in.ready && !payload_done;
            udp_echo_pkg::FILT_DISCARD: rx_payload.ready = 1'b1;
            default:                    rx_payload.ready = 1'b0;
        endcase
    end

    assign tx_hdr.hdr   = reply_hdr;
    assign tx_hdr.valid = reply_valid;

    assign last_xfer  = rx_payload.valid && rx_payload.ready && rx_payload.last;
    assign reply_xfer = reply_valid && tx_hdr.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= udp_echo_pkg::FILT_IDLE;
            reply_valid  <= 1'b0;
            payload_done <= 1'b0;
        end else begin
            case (state)
                udp_echo_pkg::FILT_IDLE: begin
                    payload_done <= 1'b0;
                    if (rx_hdr.valid) begin
                        if (match) begin
                            state       <= udp_echo_pkg::FILT_FORWARD;
                            reply_valid <= 1'b1;
                        end else begin
                            state <= udp_echo_pkg::FILT_DISCARD;
                        end
                    end
                end
                udp_echo_pkg::FILT_FORWARD: begin
                    if (reply_xfer) begin
                        reply_valid <= 1'b0;
                    end
                    if (last_xfer) begin
                        payload_done <= 1'b1;
                    end
                    // Done once both the payload end and the reply header are through
                    if ((payload_done || last_xfer) && (!reply_valid || reply_xfer)) begin
                        state        <= udp_echo_pkg::FILT_IDLE;
                        payload_done <= 1'b0;
                    end
                end
                udp_echo_pkg::FILT_DISCARD: begin
                    if (last_xfer) begin
                        state <= udp_echo_pkg::FILT_IDLE;
                    end
                end
                default: state <= udp_echo_pkg::FILT_IDLE;
            endcase
        end
    end

    // Reply swaps both endpoints
    always_ff @(posedge clk) begin
        if (rx_hdr.valid && rx_hdr.ready && match) begin
            reply_hdr.src_ip     <= rx_hdr.hdr.dst_ip;
            reply_hdr.dst_ip     <= rx_hdr.hdr.src_ip;
            reply_hdr.src_port   <= rx_hdr.hdr.dst_port;
            reply_hdr.dst_port   <= rx_hdr.hdr.src_port;
            reply_hdr.udp_length <= rx_hdr.hdr.udp_length;
        end
    end

endmodule

/* src/echo_payload_fifo.sv */
// Payload byte FIFO
`timescale 1ns/1ps

module echo_payload_fifo (
    input  logic          clk,
    input  logic          rst,
    byte_stream_if.sink   wr,
    byte_stream_if.source rd
);

    localparam int AW = udp_echo_pkg::FIFO_ADDR_WIDTH;

    // Each entry is {last, data}
    logic [8:0]  mem [2**AW];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        mem_empty;
    logic        full;
    logic        wr_xfer;
    logic        load_out;
    logic        out_valid;
    logic [8:0]  out_word;

    assign mem_empty = wr_ptr == rd_ptr;
    assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign wr.ready = !full;
    assign wr_xfer  = wr.valid && !full;
    assign load_out = !out_valid || rd.ready;

    assign rd.valid = out_valid;
    assign rd.data  = out_word[7:0];
    assign rd.last  = out_word[8];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            // Empty buffer lets an incoming byte skip straight to the output
            if (wr_xfer && !(load_out && mem_empty)) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_out) begin
                if (!mem_empty) begin
                    rd_ptr    <= rd_ptr + 1'b1;
                    out_valid <= 1'b1;
                end else begin
                    out_valid <= wr_xfer;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_xfer && !(load_out && mem_empty)) begin
            mem[wr_ptr[AW-1:0]] <= {wr.last, wr.data};
        end
        if (load_out) begin
            if (!mem_empty) begin
                out_word <= mem[rd_ptr[AW-1:0]];
            end else if (wr_xfer) begin
                out_word <= {wr.last, wr.data};
            end
        end
    end

endmodule

/* src/echo_tx_builder.sv */
// Reply frame builder
`timescale 1ns/1ps

module echo_tx_builder (
    input  logic        clk,
    input  logic        rst,
    udp_hdr_if.sink     hdr,
    byte_stream_if.sink payload,
    output logic [7:0]  out_data,
    output logic        out_valid,
    input  logic        out_ready,
    output logic        out_last,
    output logic [7:0]  led
);

    udp_echo_pkg::builder_state_e state;
    logic [223:0]                 tx_shift;
    logic [223:0]                 reply_bytes;
    logic [4:0]                   hdr_cnt;
    logic                         first_byte;
    logic [15:0]                  total_len;
    logic [15:0]                  hdr_csum;
    logic                         hdr_xfer;
    logic                         out_xfer;

    // One's complement sum over the fixed and variable header words
    function automatic logic [15:0] ip_checksum(
        input logic [31:0] src_ip,
        input logic [31:0] dst_ip,
        input logic [15:0] len
    );
        logic [19:0] sum;
        sum = 20'({udp_echo_pkg::IP_VER_IHL, 8'h00}) + 20'(len) +
              20'({udp_echo_pkg::REPLY_TTL, udp_echo_pkg::IP_PROTO_UDP}) +
              20'(src_ip[31:16]) + 20'(src_ip[15:0]) +
              20'(dst_ip[31:16]) + 20'(dst_ip[15:0]);
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);
        return ~sum[15:0];
    endfunction

    assign total_len = hdr.hdr.udp_length + 16'(udp_echo_pkg::IP_HDR_BYTES);
    assign hdr_csum  = ip_checksum(hdr.hdr.src_ip, hdr.hdr.dst_ip, total_len);

    // ID, flags, fragment offset and UDP checksum all zero
    assign reply_bytes = {
        udp_echo_pkg::IP_VER_IHL, 8'h00, total_len,
        16'h0000, 16'h0000,
        udp_echo_pkg::REPLY_TTL, udp_echo_pkg::IP_PROTO_UDP, hdr_csum,
        hdr.hdr.src_ip, hdr.hdr.dst_ip,
        hdr.hdr.src_port, hdr.hdr.dst_port, hdr.hdr.udp_length, 16'h0000
    };

    assign hdr.ready = state == udp_echo_pkg::TX_IDLE;
    assign hdr_xfer  = hdr.valid && hdr.ready;
    assign out_xfer  = out_valid && out_ready;

    always_comb begin
        out_data      = tx_shift[223:216];
        out_valid     = 1'b0;
        out_last      = 1'b0;
        payload.ready = 1'b0;
        case (state)
            udp_echo_pkg::TX_HDR: begin
                out_valid = 1'b1;
            end
            udp_echo_pkg::TX_PAYLOAD: begin
                out_data      = payload.data;
                out_valid     = payload.valid;
                out_last      = payload.last;
                payload.ready = out_ready;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= udp_echo_pkg::TX_IDLE;
            hdr_cnt    <= 5'd0;
            first_byte <= 1'b0;
            led        <= 8'h00;
        end else begin
            case (state)
                udp_echo_pkg::TX_IDLE: begin
                    if (hdr_xfer) begin
                        state   <= udp_echo_pkg::TX_HDR;
                        hdr_cnt <= 5'd0;
                    end
                end
                udp_echo_pkg::TX_HDR: begin
                    if (out_ready) begin
                        hdr_cnt <= hdr_cnt + 5'd1;
                        if (hdr_cnt == 5'(udp_echo_pkg::HDR_BYTES - 1)) begin
                            state      <= udp_echo_pkg::TX_PAYLOAD;
                            first_byte <= 1'b1;
                        end
                    end
                end
                udp_echo_pkg::TX_PAYLOAD: begin
                    if (out_xfer) begin
                        first_byte <= 1'b0;
                        if (first_byte) begin
                            led <= out_data;
                        end
                        if (out_last) begin
                            state <= udp_echo_pkg::TX_IDLE;
                        end
                    end
                end
                default: state <= udp_echo_pkg::TX_IDLE;
            endcase
        end
    end

    // Header goes out MSB byte first
    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            tx_shift <= reply_bytes;
        end else if (state == udp_echo_pkg::TX_HDR && out_ready) begin
            tx_shift <= {tx_shift[215:0], 8'h00};
        end
    end

endmodule

/* src/udp_echo_pkg.sv */
// UDP echo shared definitions

package udp_echo_pkg;

    // Responder identity
    localparam logic [31:0] LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [15:0] ECHO_PORT = 16'd1234;

    // IPv4 fields used in checks and replies
    localparam logic [7:0] REPLY_TTL    = 8'd64;
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;
    localparam logic [7:0] IP_VER_IHL   = 8'h45;

    localparam int IP_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES = 8;
    localparam int HDR_BYTES     = IP_HDR_BYTES + UDP_HDR_BYTES;

    // Payload buffer depth is 2**FIFO_ADDR_WIDTH
    localparam int FIFO_ADDR_WIDTH = 10;

    // Field order matches the wire order of bytes 12 to 25
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_length;
    } udp_hdr_t;

    typedef enum logic [1:0] {
        PARSE_HDR, PARSE_WAIT, PARSE_PAYLOAD, PARSE_DROP
    } parser_state_e;

    typedef enum logic [1:0] {
        FILT_IDLE, FILT_FORWARD, FILT_DISCARD
    } filter_state_e;

    typedef enum logic [1:0] {
        TX_IDLE, TX_HDR, TX_PAYLOAD
    } builder_state_e;

endpackage

/* src/udp_echo_top.sv */
// UDP echo responder top level
`timescale 1ns/1ps

module udp_echo_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       in_last,
    output logic [7:0] out_data,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       out_last,
    output logic [7:0] led
);

    udp_hdr_if     rx_hdr ();
    byte_stream_if rx_payload ();
    byte_stream_if fifo_in ();
    udp_hdr_if     tx_hdr ();
    byte_stream_if fifo_out ();

    udp_rx_parser rx_parser_inst (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_last  (in_last),
        .hdr      (rx_hdr),
        .payload  (rx_payload)
    );

    echo_filter filter_inst (
        .clk        (clk),
        .rst        (rst),
        .rx_hdr     (rx_hdr),
        .rx_payload (rx_payload),
        .fifo_in    (fifo_in),
        .tx_hdr     (tx_hdr)
    );

    echo_payload_fifo fifo_inst (
        .clk (clk),
        .rst (rst),
        .wr  (fifo_in),
        .rd  (fifo_out)
    );

    echo_tx_builder tx_builder_inst (
        .clk       (clk),
        .rst       (rst),
        .hdr       (tx_hdr),
        .payload   (fifo_out),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .led       (led)
    );

endmodule

/* src/udp_hdr_if.sv */
// UDP header link
`timescale 1ns/1ps

interface udp_hdr_if;

    // Header fields travel as one word
    udp_echo_pkg::udp_hdr_t hdr;
    logic                   valid;
    logic                   ready;

    modport source (
        output hdr, valid,
        input  ready
    );

    modport sink (
        input  hdr, valid,
        output ready
    );

endinterface

/* src/udp_rx_parser.sv */
// IPv4 and UDP header parser
`timescale 1ns/1ps

module udp_rx_parser (
    input  logic          clk,
    input  logic          rst,
    input  logic [7:0]    in_data,
    input  logic          in_valid,
    output logic          in_ready,
    input  logic          in_last,
    udp_hdr_if.source     hdr,
    byte_stream_if.source payload
);

    udp_echo_pkg::parser_state_e state;
    udp_echo_pkg::udp_hdr_t      hdr_reg;
    logic [4:0]                  byte_cnt;
    logic                        ver_ok;
    logic                        proto_ok;
    logic                        hdr_valid;
    logic                        in_xfer;
    logic                        hdr_done;

    assign in_xfer  = in_valid && in_ready;
    assign hdr_done = byte_cnt == 5'(udp_echo_pkg::HDR_BYTES - 1);

    always_comb begin
        case (state)
            udp_echo_pkg::PARSE_HDR:     in_ready = 1'b1;
            udp_echo_pkg::PARSE_DROP:    in_ready = 1'b1;
            udp_echo_pkg::PARSE_PAYLOAD: in_ready = payload.ready;
            default:                     in_ready = 1'b0;
        endcase
    end

    // Payload passes straight through once the header is handed off
    assign payload.data  = in_data;
    assign payload.last  = in_last;
    assign payload.valid = in_valid && (state == udp_echo_pkg::PARSE_PAYLOAD);

    assign hdr.hdr   = hdr_reg;
    assign hdr.valid = hdr_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= udp_echo_pkg::PARSE_HDR;
            byte_cnt  <= 5'd0;
            ver_ok    <= 1'b0;
            proto_ok  <= 1'b0;
            hdr_valid <= 1'b0;
        end else begin
            case (state)
                udp_echo_pkg::PARSE_HDR: begin
                    if (in_xfer) begin
                        byte_cnt <= byte_cnt + 5'd1;
                        if (byte_cnt == 5'd0) begin
                            ver_ok <= in_data == udp_echo_pkg::IP_VER_IHL;
                        end
                        // Protocol sits at byte 9 of the IPv4 header
                        if (byte_cnt == 5'd9) begin
                            proto_ok <= in_data == udp_echo_pkg::IP_PROTO_UDP;
                        end
                        if (in_last) begin
                            // Runt frame, or header with no payload
                            byte_cnt <= 5'd0;
                        end else if (hdr_done) begin
                            byte_cnt <= 5'd0;
                            if (ver_ok && proto_ok) begin
                                state     <= udp_echo_pkg::PARSE_WAIT;
                                hdr_valid <= 1'b1;
                            end else begin
                                state <= udp_echo_pkg::PARSE_DROP;
                            end
                        end
                    end
                end
                udp_echo_pkg::PARSE_WAIT: begin
                    if (hdr.ready) begin
                        hdr_valid <= 1'b0;
                        state     <= udp_echo_pkg::PARSE_PAYLOAD;
                    end
                end
                udp_echo_pkg::PARSE_PAYLOAD: begin
                    if (in_xfer && in_last) begin
                        state <= udp_echo_pkg::PARSE_HDR;
                    end
                end
                udp_echo_pkg::PARSE_DROP: begin
                    if (in_xfer && in_last) begin
                        state <= udp_echo_pkg::PARSE_HDR;
                    end
                end
                default: state <= udp_echo_pkg::PARSE_HDR;
            endcase
        end
    end

    // Bytes 12 to 25 hold addresses, ports and UDP length in struct order
    always_ff @(posedge clk) begin
        if (state == udp_echo_pkg::PARSE_HDR && in_xfer &&
            byte_cnt >= 5'd12 && byte_cnt <= 5'd25) begin
            hdr_reg <= {hdr_reg[103:0], in_data};
        end
    end

endmodule

/* testbench/udp_echo_checker.sv */
// Echo responder protocol assertions
`timescale 1ns/1ps

module udp_echo_checker (
    input logic       clk,
    input logic       rst,
    input logic [7:0] in_data,
    input logic       in_valid,
    input logic       in_ready,
    input logic [7:0] out_data,
    input logic       out_valid,
    input logic       out_ready,
    input logic       out_last,
    input logic       hdr_taken
);

    logic seen_hdr;

    // No reply can start before the builder takes its first header
    always_ff @(posedge clk) begin
        if (rst) begin
            seen_hdr <= 1'b0;
        end else if (hdr_taken) begin
            seen_hdr <= 1'b1;
        end
    end

    idle_after_reset: assert property (@(posedge clk) rst |=> !out_valid && !out_last)
        else $error("output stream active right after reset");

    idle_before_header: assert property (@(posedge clk) disable iff (rst)
        !seen_hdr |-> !out_valid && !out_last)
        else $error("output stream active before any header was accepted");

    // Stalled output must hold steady
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("output byte changed while stalled");

    in_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else $error("input byte changed while stalled");

endmodule

bind udp_echo_top udp_echo_checker protocol_checker (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last),
    .hdr_taken (tx_hdr.valid && tx_hdr.ready)
);

/* testbench/udp_echo_tb.sv */
// UDP echo responder testbench
`timescale 1ns/1ps

module udp_echo_tb;

    localparam logic [31:0] REMOTE_IP      = 32'h0A00_0007;
    localparam int          NUM_DATAGRAMS  = 20;
    localparam int          CYCLES_PER_DGM = 4000;

    logic       clk = 1'b0;
    logic       rst;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_ready;
    logic       in_last;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_ready;
    logic       out_last;
    logic [7:0] led;

    // Captured and expected streams as {last, data}
    logic [8:0] got_bytes[$];
    logic [8:0] exp_bytes[$];
    logic [7:0] got_led[$];
    logic [7:0] exp_led[$];
    logic [7:0] payload_q[$];
    logic [7:0] led_expected;
    logic       led_pending;
    logic       random_ready;
    logic       ready_pattern [0:255];
    logic [7:0] ready_idx;

    udp_echo_top UUT (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .led       (led)
    );

    always #2 clk = ~clk;

    // Output sink, fixed ready or a precomputed random pattern
    initial begin
        out_ready = 1'b1;
        ready_idx = 8'd0;
        forever begin
            @(posedge clk);
            #1;
            out_ready = random_ready ? ready_pattern[ready_idx] : 1'b1;
            ready_idx = ready_idx + 8'd1;
        end
    end

    // Sampled mid-cycle, the byte moves at the next rising edge
    always @(negedge clk) begin
        if (led_pending) begin
            got_led.push_back(led);
            led_pending = 1'b0;
        end
        if (!rst && out_valid && out_ready) begin
            got_bytes.push_back({out_last, out_data});
            if (out_last) begin
                led_pending = 1'b1;
            end
        end
    end

    initial begin
        repeat (NUM_DATAGRAMS * CYCLES_PER_DGM) @(posedge clk);
        $display("Timeout: replies did not arrive within the allowed number of cycles");
        $display("Test failed");
        $fatal(1);
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [15:0] header_checksum(input logic [159:0] ip_hdr);
        logic [31:0] sum;
        sum = 32'h0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 32'(ip_hdr[159 - 16*i -: 16]);
        end
        while (sum[31:16] != 16'h0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        return ~sum[15:0];
    endfunction

    // Reply for the datagram currently held in payload_q
    task automatic expect_reply(input logic [15:0] req_src_port, input int len);
        logic [159:0] ip_hdr;
        logic [223:0] reply;
        ip_hdr = {8'h45, 8'h00, 16'(len + 28), 32'h0, 8'd64, 8'd17, 16'h0000,
                  udp_echo_pkg::LOCAL_IP, REMOTE_IP};
        ip_hdr[79:64] = header_checksum(ip_hdr);
        reply = {ip_hdr, udp_echo_pkg::ECHO_PORT, req_src_port, 16'(len + 8), 16'h0000};
        for (int i = 0; i < 28; i++) begin
            exp_bytes.push_back({1'b0, reply[223 - 8*i -: 8]});
        end
        for (int i = 0; i < len; i++) begin
            exp_bytes.push_back({i == len - 1, payload_q[i]});
        end
        exp_led.push_back(payload_q[0]);
    endtask

    task automatic drive_byte(input logic [7:0] data, input logic last);
        logic taken;
        in_data  = data;
        in_valid = 1'b1;
        in_last  = last;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic send_datagram(input logic [7:0] ver_ihl, input logic [7:0] proto,
                                 input logic [31:0] dst_ip, input logic [15:0] dst_port,
                                 input int len, input logic echoed);
        logic [223:0] req;
        logic [15:0]  src_port;
        src_port = 16'($urandom);
        payload_q.delete();
        for (int i = 0; i < len; i++) begin
            payload_q.push_back(8'($urandom));
        end
        // Request TTL and checksum are arbitrary, the receiver ignores them
        req = {ver_ihl, 8'h00, 16'(len + 28), 32'h0, 8'd32, proto, 16'h0000,
               REMOTE_IP, dst_ip, src_port, dst_port, 16'(len + 8), 16'h0000};
        if (echoed) begin
            expect_reply(src_port, len);
        end
        for (int i = 0; i < 28; i++) begin
            drive_byte(req[223 - 8*i -: 8], 1'b0);
        end
        for (int i = 0; i < len; i++) begin
            drive_byte(payload_q[i], i == len - 1);
        end
    endtask

    task automatic wait_replies(input int n);
        while (got_led.size() < n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic compare_replies();
        check_value("reply byte count", 32'(got_bytes.size()), 32'(exp_bytes.size()));
        for (int i = 0; i < exp_bytes.size(); i++) begin
            check_value($sformatf("reply byte %0d", i), 32'(got_bytes[i]), 32'(exp_bytes[i]));
        end
        check_value("reply count", 32'(got_led.size()), 32'(exp_led.size()));
        for (int i = 0; i < exp_led.size(); i++) begin
            check_value($sformatf("led after reply %0d", i), 32'(got_led[i]), 32'(exp_led[i]));
        end
        led_expected = exp_led[exp_led.size() - 1];
        got_bytes.delete();
        exp_bytes.delete();
        got_led.delete();
        exp_led.delete();
    endtask

    task automatic echo_single();
        int len;
        for (int k = 0; k < 4; k++) begin
            len = (k == 0) ? 1 : (k == 1) ? 40 : int'(1 + ($urandom % 40));
            send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT,
                          len, 1'b1);
            wait_replies(1);
            compare_replies();
        end
    endtask

    task automatic drop_wrong_address();
        send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP, 16'd1235, 12, 1'b0);
        send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP ^ 32'h1, udp_echo_pkg::ECHO_PORT,
                      9, 1'b0);
        check_value("led after dropped address", 32'(led), 32'(led_expected));
        send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT, 7, 1'b1);
        wait_replies(1);
        compare_replies();
    endtask

    task automatic drop_bad_header();
        send_datagram(8'h46, 8'd17, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT, 5, 1'b0);
        send_datagram(8'h45, 8'd6, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT, 5, 1'b0);
        check_value("led after bad header", 32'(led), 32'(led_expected));
        send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT, 3, 1'b1);
        wait_replies(1);
        compare_replies();
    endtask

    task automatic echo_under_backpressure();
        random_ready = 1'b1;
        for (int k = 0; k < 4; k++) begin
            send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT,
                          int'(1 + ($urandom % 40)), 1'b1);
            wait_replies(1);
            compare_replies();
        end
        random_ready = 1'b0;
    endtask

    // Next datagram goes in while the previous reply is still going out
    task automatic echo_back_to_back();
        send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT, 20, 1'b1);
        send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP, 16'd80, 6, 1'b0);
        send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT, 1, 1'b1);
        send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT, 33, 1'b1);
        send_datagram(8'h44, 8'd17, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT, 4, 1'b0);
        send_datagram(8'h45, 8'd17, udp_echo_pkg::LOCAL_IP, udp_echo_pkg::ECHO_PORT, 2, 1'b1);
        wait_replies(4);
        compare_replies();
    endtask

    initial begin
        rst          = 1'b1;
        in_data      = 8'h00;
        in_valid     = 1'b0;
        in_last      = 1'b0;
        random_ready = 1'b0;
        led_pending  = 1'b0;
        led_expected = 8'h00;
        void'($urandom(39219));
        for (int i = 0; i < 256; i++) begin
            ready_pattern[i] = 1'($urandom % 2);
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("led after reset", 32'(led), 32'h0);

        echo_single();
        drop_wrong_address();
        drop_bad_header();
        echo_under_backpressure();
        echo_back_to_back();

        $display("Test passed");
        $finish;
    end

endmodule
